//--- include/cpuDma_params.svh
// CPU DMA sequencer constants for acknowledge encodings and field widths
`ifndef CPU_DMA_PARAMS_SVH
`define CPU_DMA_PARAMS_SVH

// {nDSACK1, nDSACK0} as seen on the pins
`define CPU_DMA_ACK_LONG 2'b00
`define CPU_DMA_ACK_WORD 2'b01
`define CPU_DMA_ACK_NONE 2'b11

`define CPU_DMA_PHASE_WIDTH 3
`define CPU_DMA_KIND_WIDTH 2
`define CPU_DMA_TERM_WIDTH 2

`endif

//--- hw/cpuDmaPkg.sv
// CPU DMA shared types for transfer direction, bus termination and sequencer phase
`default_nettype none

`include "cpuDma_params.svh"

package cpuDmaPkg;

    typedef enum logic [`CPU_DMA_KIND_WIDTH-1:0] {
        none,
        fifoToCpu,                           // FIFO to memory
        cpuToFifo                            // Memory to FIFO
    } xferKind_t;

    typedef enum logic [`CPU_DMA_TERM_WIDTH-1:0] {
        termWait,
        termLong,                            // 32-bit DSACK
        termWord,                            // 16-bit DSACK
        termSync                             // STERM
    } termKind_t;

    typedef enum logic [`CPU_DMA_PHASE_WIDTH-1:0] {
        phaseIdle,
        phaseRequest,
        phaseGranted,
        phaseData,
        phaseRelease
    } busPhase_t;

endpackage

`default_nettype wire

//--- hw/ackDecode.sv
// Bus termination decode registering DSACK and STERM and classifying the result
`timescale 1ns/100ps
`default_nettype none

`include "cpuDma_params.svh"

module ackDecode import cpuDmaPkg::*; (
    input  logic      CLK,
    input  logic      nRESET,
    input  logic      nDSACK0,
    input  logic      nDSACK1,
    input  logic      nSTERM,
    output termKind_t term
);

    logic [1:0] dsackQ;                      // {nDSACK1, nDSACK0}
    logic       stermQ;

    always_ff @(posedge CLK or negedge nRESET) begin
        if (!nRESET) begin
            dsackQ <= `CPU_DMA_ACK_NONE;
            stermQ <= 1'b1;
        end else begin
            dsackQ <= {nDSACK1, nDSACK0};
            stermQ <= nSTERM;
        end
    end

    always_comb begin
        if (!stermQ) begin
            term = termSync;                 // STERM wins
        end else begin
            case (dsackQ)
                `CPU_DMA_ACK_LONG: term = termLong;
                `CPU_DMA_ACK_WORD: term = termWord;
                default:           term = termWait;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/transferDecode.sv
// Transfer request decode holding a pending longword request and the flush stop level
`timescale 1ns/100ps
`default_nettype none

module transferDecode import cpuDmaPkg::*; (
    input  logic      CLK,
    input  logic      nRESET,
    input  logic      DMAENA,
    input  logic      DMADIR,
    input  logic      DREQ,
    input  logic      FIFOEMPTY,
    input  logic      FIFOFULL,
    input  logic      FLUSHFIFO,
    input  logic      LASTWORD,
    input  logic      xferTaken,
    output logic      xferReq,
    output logic      STOPFLUSH,
    output xferKind_t xferKind
);

    logic startToCpu;
    logic startToFifo;
    logic flushEnd;

    // Full FIFO, or a flush with data left
    assign startToCpu  = DMAENA & DMADIR & (FIFOFULL | (FLUSHFIFO & ~FIFOEMPTY));
    assign startToFifo = DMAENA & ~DMADIR & DREQ & ~FIFOFULL; // Room for one more longword
    assign flushEnd    = DMAENA & DMADIR & FLUSHFIFO & FIFOEMPTY & LASTWORD;

    always_ff @(posedge CLK or negedge nRESET) begin
        if (!nRESET) begin
            xferReq   <= 1'b0;
            xferKind  <= none;
            STOPFLUSH <= 1'b0;
        end else begin
            STOPFLUSH <= flushEnd;
            if (xferTaken) begin
                xferReq <= 1'b0;
            end else if (!xferReq && (startToCpu || startToFifo)) begin
                xferReq  <= 1'b1;
                xferKind <= startToCpu ? fifoToCpu : cpuToFifo; // Frozen while pending
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/busCycleSequencer.sv
// Bus cycle FSM for arbitration, strobes and 16-bit half-cycle sequencing
`timescale 1ns/100ps
`default_nettype none

`include "cpuDma_params.svh"

module busCycleSequencer import cpuDmaPkg::*; (
    input  logic      CLK,
    input  logic      nRESET,
    input  logic      xferReq,
    input  logic      BGRANT,
    input  xferKind_t xferKind,
    input  termKind_t term,
    output logic      xferTaken,
    output logic      BREQ,
    output logic      BGACK,
    output logic      PAS,
    output logic      PDS,
    output logic      SIZE1,
    output logic      secondHalf,
    output logic      halfDone,
    output logic      cycleDone,
    output termKind_t halfTerm,
    output busPhase_t phase,
    output xferKind_t kind
);

    logic halfGap;                           // Strobes off between halves
    logic termWasWait;
    logic termHit;

    // Only a fresh acknowledge ends a half, a held one from the last half is ignored
    assign termHit = (term != termWait) && termWasWait;

    always_ff @(posedge CLK or negedge nRESET) begin
        if (!nRESET) begin
            phase       <= phaseIdle;
            kind        <= none;
            xferTaken   <= 1'b0;
            BREQ        <= 1'b0;
            BGACK       <= 1'b0;
            PAS         <= 1'b0;
            PDS         <= 1'b0;
            SIZE1       <= 1'b0;
            secondHalf  <= 1'b0;
            halfGap     <= 1'b0;
            halfDone    <= 1'b0;
            cycleDone   <= 1'b0;
            halfTerm    <= termWait;
            termWasWait <= 1'b1;
        end else begin
            xferTaken   <= 1'b0;
            halfDone    <= 1'b0;
            cycleDone   <= 1'b0;
            termWasWait <= (term == termWait);
            case (phase)
                phaseIdle: begin
                    if (xferReq) begin
                        phase     <= phaseRequest;
                        kind      <= xferKind;
                        xferTaken <= 1'b1;
                        BREQ      <= 1'b1;
                    end
                end
                phaseRequest: begin
                    if (BGRANT) begin
                        phase <= phaseGranted;
                        BREQ  <= 1'b0;
                        BGACK <= 1'b1;
                    end
                end
                phaseGranted: begin
                    phase <= phaseData;
                    PAS   <= 1'b1;
                    PDS   <= 1'b1;
                end
                phaseData: begin
                    if (halfGap) begin
                        halfGap    <= 1'b0;
                        secondHalf <= 1'b1;
                        SIZE1      <= 1'b1;
                        PAS        <= 1'b1;
                        PDS        <= 1'b1;
                    end else if (termHit) begin
                        halfDone <= 1'b1;
                        halfTerm <= term;
                        PAS      <= 1'b0;
                        PDS      <= 1'b0;
                        SIZE1    <= 1'b0;
                        if (term == termWord && !secondHalf) begin
                            halfGap <= 1'b1;  // 16-bit port, upper word done
                        end else begin
                            cycleDone <= 1'b1;
                            phase     <= phaseRelease;
                        end
                    end
                end
                phaseRelease: begin
                    phase      <= phaseIdle;
                    BGACK      <= 1'b0;
                    secondHalf <= 1'b0;      // Held until here for the lane pulses
                end
                default: begin
                    phase <= phaseIdle;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hw/dataLaneSteer.sv
// Data lane steering and FIFO and counter bookkeeping pulses for each bus cycle
`timescale 1ns/100ps
`default_nettype none

module dataLaneSteer import cpuDmaPkg::*; (
    input  logic      CLK,
    input  logic      nRESET,
    input  logic      secondHalf,
    input  logic      halfDone,
    input  logic      cycleDone,
    input  busPhase_t phase,
    input  xferKind_t kind,
    input  termKind_t halfTerm,
    output logic      F2CPUL,
    output logic      F2CPUH,
    output logic      BRIDGEOUT,
    output logic      DIEH,
    output logic      DIEL,
    output logic      BRIDGEIN,
    output logic      PLLW,
    output logic      PLHW,
    output logic      INCFIFO,
    output logic      DECFIFO,
    output logic      INCNO,
    output logic      INCNI
);

    logic toCpu;
    logic toFifo;
    logic isRead;

    assign toCpu  = (phase == phaseData) && (kind == fifoToCpu);
    assign toFifo = (phase == phaseData) && (kind == cpuToFifo);
    assign isRead = (kind == cpuToFifo);

    assign F2CPUL    = toCpu;
    assign F2CPUH    = toCpu & ~secondHalf;
    assign BRIDGEOUT = toCpu & secondHalf;    // Low word onto upper lanes
    assign DIEH      = toFifo & ~secondHalf;
    assign DIEL      = toFifo & ~secondHalf;
    assign BRIDGEIN  = toFifo & secondHalf;   // Upper lanes into low word

    always_ff @(posedge CLK or negedge nRESET) begin
        if (!nRESET) begin
            PLHW    <= 1'b0;
            PLLW    <= 1'b0;
            DECFIFO <= 1'b0;
            INCNO   <= 1'b0;
            INCFIFO <= 1'b0;
            INCNI   <= 1'b0;
        end else begin
            PLHW    <= halfDone & isRead & ~secondHalf;
            // Word port fills only the high half first
            PLLW    <= halfDone & isRead & (secondHalf | (halfTerm != termWord));
            DECFIFO <= cycleDone & (kind == fifoToCpu);
            INCNO   <= cycleDone & (kind == fifoToCpu);
            INCFIFO <= cycleDone & isRead;
            INCNI   <= cycleDone & isRead;
        end
    end

endmodule

`default_nettype wire

//--- hw/cpuDmaTop.sv
// CPU DMA bus sequencer top connecting request decode, bus FSM and lane steering
`timescale 1ns/100ps
`default_nettype none

module cpuDmaTop import cpuDmaPkg::*; (
    input  logic CLK,
    input  logic nRESET,
    input  logic DMAENA,
    input  logic DMADIR,
    input  logic DREQ,
    input  logic FIFOEMPTY,
    input  logic FIFOFULL,
    input  logic FLUSHFIFO,
    input  logic LASTWORD,
    input  logic BGRANT,
    input  logic nDSACK0,
    input  logic nDSACK1,
    input  logic nSTERM,
    output logic BREQ,
    output logic BGACK,
    output logic PAS,
    output logic PDS,
    output logic SIZE1,
    output logic F2CPUL,
    output logic F2CPUH,
    output logic BRIDGEOUT,
    output logic PLLW,
    output logic PLHW,
    output logic DIEH,
    output logic DIEL,
    output logic BRIDGEIN,
    output logic INCFIFO,
    output logic DECFIFO,
    output logic INCNO,
    output logic INCNI,
    output logic STOPFLUSH
);

    logic       xferReq;
    logic       xferTaken;
    xferKind_t  xferKind;
    termKind_t  term;
    termKind_t  halfTerm;
    busPhase_t  phase;
    xferKind_t  kind;
    logic       secondHalf;
    logic       halfDone;
    logic       cycleDone;

    transferDecode uDecode (
        .CLK(CLK), .nRESET(nRESET),
        .DMAENA(DMAENA), .DMADIR(DMADIR), .DREQ(DREQ),
        .FIFOEMPTY(FIFOEMPTY), .FIFOFULL(FIFOFULL),
        .FLUSHFIFO(FLUSHFIFO), .LASTWORD(LASTWORD),
        .xferTaken(xferTaken), .xferReq(xferReq),
        .STOPFLUSH(STOPFLUSH), .xferKind(xferKind)
    );

    ackDecode uAck (
        .CLK(CLK), .nRESET(nRESET),
        .nDSACK0(nDSACK0), .nDSACK1(nDSACK1), .nSTERM(nSTERM),
        .term(term)
    );

    busCycleSequencer uSeq (
        .CLK(CLK), .nRESET(nRESET),
        .xferReq(xferReq), .BGRANT(BGRANT), .xferKind(xferKind), .term(term),
        .xferTaken(xferTaken), .BREQ(BREQ), .BGACK(BGACK),
        .PAS(PAS), .PDS(PDS), .SIZE1(SIZE1),
        .secondHalf(secondHalf), .halfDone(halfDone), .cycleDone(cycleDone),
        .halfTerm(halfTerm), .phase(phase), .kind(kind)
    );

    dataLaneSteer uLanes (
        .CLK(CLK), .nRESET(nRESET),
        .secondHalf(secondHalf), .halfDone(halfDone), .cycleDone(cycleDone),
        .phase(phase), .kind(kind), .halfTerm(halfTerm),
        .F2CPUL(F2CPUL), .F2CPUH(F2CPUH), .BRIDGEOUT(BRIDGEOUT),
        .DIEH(DIEH), .DIEL(DIEL), .BRIDGEIN(BRIDGEIN),
        .PLLW(PLLW), .PLHW(PLHW),
        .INCFIFO(INCFIFO), .DECFIFO(DECFIFO), .INCNO(INCNO), .INCNI(INCNI)
    );

endmodule

`default_nettype wire

//--- test/cpuDma_chk.sv
// Bus protocol checker for arbitration and strobe ordering in the sequencer
`timescale 1ns/100ps
`default_nettype none

module cpuDma_chk (
    input logic CLK,
    input logic nRESET,
    input logic BGRANT,
    input logic BREQ,
    input logic BGACK,
    input logic PAS,
    input logic xferTaken
);

    strobeNeedsBus: assert property (@(posedge CLK) disable iff (!nRESET) PAS |-> BGACK)
        else $error("PAS asserted while BGACK is low");

    ackAfterGrant: assert property (@(posedge CLK) disable iff (!nRESET)
        $rose(BGACK) |-> $past(BGRANT))
        else $error("BGACK rose without a preceding BGRANT");

    reqAckApart: assert property (@(posedge CLK) disable iff (!nRESET)
        !($rose(BREQ) && $rose(BGACK)))
        else $error("BREQ and BGACK rose in the same cycle");

    takenPulse: assert property (@(posedge CLK) disable iff (!nRESET) xferTaken |=> !xferTaken)
        else $error("xferTaken held longer than one cycle");

endmodule

bind busCycleSequencer cpuDma_chk uChk (
    .CLK(CLK),
    .nRESET(nRESET),
    .BGRANT(BGRANT),
    .BREQ(BREQ),
    .BGACK(BGACK),
    .PAS(PAS),
    .xferTaken(xferTaken)
);

`default_nettype wire

//--- test/tb_cpuDma.sv
// Table-driven testbench for the CPU DMA bus sequencer with arbiter and port responder
`timescale 1ns/100ps
`default_nettype none

`include "cpuDma_params.svh"

module tb_cpuDma import cpuDmaPkg::*; ();

    typedef struct packed {
        logic      ena, dir, dreq, full, empty, flush, last;
        termKind_t resp;                     // How the port answers
        int        grantDelay;
        logic      xfer;                     // Bus transfer expected
        int        pas, plhw, pllw, plBoth;
        int        dec;                      // DECFIFO and INCNO
        int        inc;                      // INCFIFO and INCNI
        logic      stop;
    } xferRow_t;

    localparam int numRows     = 10;
    localparam int xferTimeout = 80;
    localparam int quietCycles = 20;

    logic CLK = 1'b0;
    logic nRESET, DMAENA, DMADIR, DREQ, FIFOEMPTY, FIFOFULL, FLUSHFIFO, LASTWORD;
    logic BGRANT, nDSACK0, nDSACK1, nSTERM;
    logic BREQ, BGACK, PAS, PDS, SIZE1, F2CPUL, F2CPUH, BRIDGEOUT, PLLW, PLHW;
    logic DIEH, DIEL, BRIDGEIN, INCFIFO, DECFIFO, INCNO, INCNI, STOPFLUSH;
    logic [17:0] ctrlOuts;
    xferRow_t rows [numRows];
    int errorCount = 0;
    int timeoutCount = 0;

    assign ctrlOuts = {BREQ, BGACK, PAS, PDS, SIZE1, F2CPUL, F2CPUH, BRIDGEOUT, PLLW, PLHW,
                       DIEH, DIEL, BRIDGEIN, INCFIFO, DECFIFO, INCNO, INCNI, STOPFLUSH};

    always #5 CLK = ~CLK;

    cpuDmaTop DUT (.*);

    task automatic checkValue(input string name, input int expected, input int actual);
        assert (actual == expected) else begin
            $display("CHECK FAILED at %0t: %s expected %0d, got %0d",
                     $time, name, expected, actual);
            errorCount++;
        end
    endtask

    task automatic runRow(input int idx, input xferRow_t r);
        int   cycles = 0;
        int   waitLeft = 0;
        int   grantLeft = 0;
        int   ackState = 0;                  // 0 idle, 1 wait states, 2 answering
        int   pas = 0, plhw = 0, pllw = 0, plBoth = 0;
        int   pds = 0;
        int   dec = 0, incNo = 0, inc = 0, incNi = 0;
        logic word, reqSeen = 0, granted = 0, sawBgack = 0, done = 0, prevPas = 0;
        logic sawH = 0, sawBo = 0, sawBi = 0, sawSize1 = 0, sawStop = 0;
        logic sawL = 0, sawDieH = 0, sawDieL = 0, prevPds = 0;
        word = (r.resp == termWord);
        @(posedge CLK);
        DMAENA    <= r.ena;
        DMADIR    <= r.dir;
        DREQ      <= r.dreq;
        FIFOFULL  <= r.full;
        FIFOEMPTY <= r.empty;
        FLUSHFIFO <= r.flush;
        LASTWORD  <= r.last;
        while (!done && cycles < xferTimeout) begin
            @(negedge CLK);
            cycles++;
            if (!r.xfer) checkValue("BREQ", 0, BREQ);
            if (!granted) checkValue("BGACK", 0, BGACK);
            if (PAS && !prevPas) pas++;
            if (PAS) checkValue("SIZE1", (pas == 2), SIZE1); // Only on the second half
            prevPas = PAS;
            if (PDS && !prevPds) pds++;
            prevPds = PDS;
            plhw   += PLHW;
            pllw   += PLLW;
            plBoth += PLHW & PLLW;
            dec    += DECFIFO;
            incNo  += INCNO;
            inc    += INCFIFO;
            incNi  += INCNI;
            sawH     |= F2CPUH;
            sawL     |= F2CPUL;
            sawBo    |= BRIDGEOUT;
            sawDieH  |= DIEH;
            sawDieL  |= DIEL;
            sawBi    |= BRIDGEIN;
            sawSize1 |= SIZE1;
            sawStop  |= STOPFLUSH;
            sawBgack |= BGACK;
            done = r.xfer ? (sawBgack && !BGACK) : (cycles >= quietCycles);
            if (BREQ && !reqSeen) begin
                reqSeen   = 1'b1;
                grantLeft = r.grantDelay + $urandom_range(0, 2);
            end
            if (reqSeen && !granted) begin
                if (grantLeft == 0) granted = 1'b1;
                else grantLeft--;
            end
            if (!PAS) begin
                ackState = 0;                // Release the port lines once the strobe drops
            end else if (ackState == 0) begin
                ackState = 1;
                waitLeft = $urandom_range(0, 3);
            end
            if (ackState == 1) begin
                if (waitLeft == 0) ackState = 2;
                else waitLeft--;
            end
            @(posedge CLK);
            BGRANT <= granted && !sawBgack;
            if (reqSeen) begin
                DMAENA    <= 1'b0;           // Accepted, so no second longword
                DREQ      <= 1'b0;
                FIFOFULL  <= 1'b0;
                FLUSHFIFO <= 1'b0;
            end
            nSTERM <= !(ackState == 2 && r.resp == termSync);
            if (ackState == 2 && r.resp == termLong)
                {nDSACK1, nDSACK0} <= `CPU_DMA_ACK_LONG;
            else if (ackState == 2 && word)
                {nDSACK1, nDSACK0} <= `CPU_DMA_ACK_WORD;
            else
                {nDSACK1, nDSACK0} <= `CPU_DMA_ACK_NONE;
        end
        if (!done) begin
            $display("Timeout at %0t: row %0d never released the bus", $time, idx);
            timeoutCount++;
        end
        DMAENA    <= 1'b0;
        DREQ      <= 1'b0;
        FIFOFULL  <= 1'b0;
        FLUSHFIFO <= 1'b0;
        BGRANT    <= 1'b0;
        checkValue("PAS count", r.pas, pas);
        checkValue("PDS count", r.pas, pds);
        checkValue("PLHW count", r.plhw, plhw);
        checkValue("PLLW count", r.pllw, pllw);
        checkValue("PLHW with PLLW", r.plBoth, plBoth);
        checkValue("DECFIFO count", r.dec, dec);
        checkValue("INCNO count", r.dec, incNo);
        checkValue("INCFIFO count", r.inc, inc);
        checkValue("INCNI count", r.inc, incNi);
        checkValue("F2CPUH seen", r.xfer && r.dir, sawH);
        checkValue("F2CPUL seen", r.xfer && r.dir, sawL);
        checkValue("BRIDGEOUT seen", r.xfer && r.dir && word, sawBo);
        checkValue("DIEH seen", r.xfer && !r.dir, sawDieH);
        checkValue("DIEL seen", r.xfer && !r.dir, sawDieL);
        checkValue("BRIDGEIN seen", r.xfer && !r.dir && word, sawBi);
        checkValue("SIZE1 seen", r.xfer && word, sawSize1);
        checkValue("STOPFLUSH seen", r.stop, sawStop);
        repeat (4) begin
            @(negedge CLK);
            checkValue("BREQ", 0, BREQ);     // Nothing restarts once cleared
        end
        checkValue("STOPFLUSH", 0, STOPFLUSH);
    endtask

    initial begin
        int k;
        void'($urandom(77678));
        nRESET    = 1'b0;
        DMAENA    = 1'b0;
        DMADIR    = 1'b0;
        DREQ      = 1'b0;
        FIFOEMPTY = 1'b1;
        FIFOFULL  = 1'b0;
        FLUSHFIFO = 1'b0;
        LASTWORD  = 1'b0;
        BGRANT    = 1'b0;
        nDSACK0   = 1'b1;
        nDSACK1   = 1'b1;
        nSTERM    = 1'b1;
        // ena dir dreq full empty flush last resp gnt xfer pas plhw pllw both dec inc stop
        rows[0] = '{1, 1, 0, 1, 0, 0, 0, termLong, 0, 1, 1, 0, 0, 0, 1, 0, 0};
        rows[1] = '{1, 1, 0, 0, 0, 1, 1, termSync, 3, 1, 1, 0, 0, 0, 1, 0, 0};
        rows[2] = '{1, 1, 0, 1, 0, 0, 0, termWord, 1, 1, 2, 0, 0, 0, 1, 0, 0};
        rows[3] = '{1, 0, 1, 0, 1, 0, 0, termLong, 2, 1, 1, 1, 1, 1, 0, 1, 0};
        rows[4] = '{1, 0, 1, 0, 1, 0, 0, termWord, 0, 1, 2, 1, 1, 0, 0, 1, 0};
        rows[5] = '{1, 0, 1, 0, 0, 0, 0, termSync, 4, 1, 1, 1, 1, 1, 0, 1, 0};
        rows[6] = '{0, 1, 0, 1, 0, 0, 0, termLong, 0, 0, 0, 0, 0, 0, 0, 0, 0};
        rows[7] = '{1, 0, 1, 1, 0, 0, 0, termLong, 0, 0, 0, 0, 0, 0, 0, 0, 0};
        rows[8] = '{1, 1, 0, 0, 1, 1, 1, termLong, 0, 0, 0, 0, 0, 0, 0, 0, 1};
        rows[9] = '{1, 1, 0, 0, 0, 1, 0, termWord, 2, 1, 2, 0, 0, 0, 1, 0, 0};
        for (k = 0; k < 8; k++) begin
            @(negedge CLK);
            checkValue("control outputs in reset", 0, ctrlOuts);
        end
        @(posedge CLK);
        nRESET <= 1'b1;
        repeat (3) begin
            @(negedge CLK);
            checkValue("control outputs after reset", 0, ctrlOuts);
        end
        for (k = 0; k < numRows; k++) begin
            runRow(k, rows[k]);
        end
        $display("Checks failed: %0d, timeouts: %0d", errorCount, timeoutCount);
        if (errorCount == 0 && timeoutCount == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- cpuDma.f
+incdir+include
hw/cpuDmaPkg.sv
hw/ackDecode.sv
hw/transferDecode.sv
hw/busCycleSequencer.sv
hw/dataLaneSteer.sv
hw/cpuDmaTop.sv
test/cpuDma_chk.sv
test/tb_cpuDma.sv
